// File: logic/sd_proto_pkg.sv
package sd_proto_pkg;

    // ==============================
    // Frame geometry
    // ==============================

    // Start, transmission, index, argument, CRC7, end
    localparam int FRAME_BITS = 48;

    // Everything the CRC covers, start bit through argument
    localparam int PAYLOAD_BITS = 40;

    // ==============================
    // Frame types
    // ==============================

    typedef logic [FRAME_BITS-1:0] frame_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [6:0] crc7_t;

    // x^7 + x^3 + 1, with the x^7 term implied
    localparam crc7_t CRC7_POLY = 7'h09;

endpackage

// File: logic/sd_ctrl_pkg.sv
package sd_ctrl_pkg;

    // Half of one SD clock period, counted in clk_fast cycles
    typedef logic [7:0] half_period_t;

    // Command transmitter
    typedef enum logic [1:0] {TX_IDLE, TX_WAIT_EDGE, TX_SHIFT, TX_DONE} tx_state_t;

    // Response receiver
    typedef enum logic [1:0] {RX_IDLE, RX_SEARCH, RX_SHIFT, RX_CHECK} rx_state_t;

    // ==============================
    // Timing
    // ==============================

    // Longest wait for a response start bit, in SD clocks
    localparam int NCR_MAX = 64;

    // 400 kHz identification rate at 120 MHz
    localparam int SLOW_HALF_PERIOD_DEFAULT = 150;

endpackage

// File: logic/sd_cmd_line_if.sv
interface sd_cmd_line_if;

    // Bit timing from the clock generator
    logic drive_tick;
    logic sample_tick;

    // CMD pad
    logic cmd_out;
    logic cmd_oe;
    logic cmd_in;

    modport clk (output drive_tick, output sample_tick);

    modport tx (input drive_tick, output cmd_out, output cmd_oe);

    modport rx (input sample_tick, input cmd_in);

endinterface

// File: logic/sd_link_cfg.sv
module sd_link_cfg #(
    parameter int CLK_FREQ_HZ = 120_000_000
) (
    input  logic                      clk_fast,
    input  logic                      arst_n,
    input  logic                      cfg_write,
    input  sd_ctrl_pkg::half_period_t cfg_half_period,
    input  logic                      cfg_clk_en,
    output sd_ctrl_pkg::half_period_t half_period,
    output logic                      clk_en
);

    // Round up so the identification clock never exceeds 400 kHz
    localparam int DERIVED_HALF = (CLK_FREQ_HZ + 799_999) / 800_000;

    // Fall back to the 120 MHz setting when the divider cannot hold it
    localparam int RESET_HALF = (DERIVED_HALF >= 1 && DERIVED_HALF <= 255) ?
                                DERIVED_HALF : sd_ctrl_pkg::SLOW_HALF_PERIOD_DEFAULT;

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            half_period <= sd_ctrl_pkg::half_period_t'(RESET_HALF);
            clk_en      <= 1'b1;
        end else if (cfg_write) begin
            // Zero would stall the divider
            if (cfg_half_period == '0) begin
                half_period <= sd_ctrl_pkg::half_period_t'(1);
            end else begin
                half_period <= cfg_half_period;
            end
            clk_en <= cfg_clk_en;
        end
    end

endmodule

// File: logic/sd_clock_gen.sv
module sd_clock_gen (
    input  logic                      clk_fast,
    input  logic                      arst_n,
    input  sd_ctrl_pkg::half_period_t half_period,
    input  logic                      clk_en,
    output logic                      sdcard_clk,
    sd_cmd_line_if.clk                line
);

    // Cycles left in the current half-period
    sd_ctrl_pkg::half_period_t count;

    logic toggle;

    // While disabled, a high phase still runs out so the clock parks low cleanly
    assign toggle = (count == '0) && (clk_en || sdcard_clk);

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            count           <= '0;
            sdcard_clk      <= 1'b0;
            line.drive_tick  <= 1'b0;
            line.sample_tick <= 1'b0;
        end else begin
            line.drive_tick  <= 1'b0;
            line.sample_tick <= 1'b0;

            if (toggle) begin
                sdcard_clk <= ~sdcard_clk;
                count      <= half_period - 1'b1;

                // Ticks land in the same cycle as the new clock level
                line.drive_tick  <= sdcard_clk;
                line.sample_tick <= ~sdcard_clk;
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/sd_crc7.sv
module sd_crc7 (
    input  logic                clk_fast,
    input  logic                arst_n,
    input  logic                clear,
    input  logic                en,
    input  logic                bit_in,
    output sd_proto_pkg::crc7_t crc
);

    logic feedback;

    // MSB first, as the bits go out on the line
    assign feedback = bit_in ^ crc[6];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            if (feedback) begin
                crc <= {crc[5:0], 1'b0} ^ sd_proto_pkg::CRC7_POLY;
            end else begin
                crc <= {crc[5:0], 1'b0};
            end
        end
    end

endmodule

// File: logic/sd_cmd_tx.sv
module sd_cmd_tx (
    input  logic                  clk_fast,
    input  logic                  arst_n,
    input  logic                  cmd_start,
    input  sd_proto_pkg::payload_t cmd_payload,
    input  logic                  resp_expect,
    output logic                  cmd_busy,
    output logic                  cmd_done,
    output logic                  resp_arm,
    sd_cmd_line_if.tx             line
);

    sd_ctrl_pkg::tx_state_t state;
    sd_proto_pkg::payload_t shreg;
    sd_proto_pkg::crc7_t    crc;

    logic [5:0] bit_cnt;
    logic       resp_expect_q;
    logic       accept;
    logic       shifting;
    logic       crc_en;
    logic [2:0] crc_idx;
    logic       next_bit;

    assign accept   = (state == sd_ctrl_pkg::TX_IDLE) && cmd_start;
    assign shifting = line.drive_tick &&
                      (state == sd_ctrl_pkg::TX_WAIT_EDGE || state == sd_ctrl_pkg::TX_SHIFT);
    assign crc_en   = shifting && (bit_cnt < 6'(sd_proto_pkg::PAYLOAD_BITS));
    assign cmd_busy = (state != sd_ctrl_pkg::TX_IDLE);

    // Bit 40 of the frame carries crc[6]
    assign crc_idx = 3'(6'(sd_proto_pkg::FRAME_BITS - 2) - bit_cnt);

    // ==============================
    // Next bit on the line
    // ==============================
    always_comb begin
        if (bit_cnt < 6'(sd_proto_pkg::PAYLOAD_BITS)) begin
            next_bit = shreg[sd_proto_pkg::PAYLOAD_BITS-1];
        end else if (bit_cnt < 6'(sd_proto_pkg::FRAME_BITS - 1)) begin
            next_bit = crc[crc_idx];
        end else begin
            next_bit = 1'b1;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (accept) begin
            shreg <= cmd_payload;
        end else if (crc_en) begin
            shreg <= shreg << 1;
        end
    end

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state         <= sd_ctrl_pkg::TX_IDLE;
            bit_cnt       <= '0;
            resp_expect_q <= 1'b0;
            cmd_done      <= 1'b0;
            resp_arm      <= 1'b0;
            line.cmd_oe   <= 1'b0;
            line.cmd_out  <= 1'b1;
        end else begin
            cmd_done <= 1'b0;
            resp_arm <= 1'b0;
            case (state)
                sd_ctrl_pkg::TX_IDLE: begin
                    if (cmd_start) begin
                        resp_expect_q <= resp_expect;
                        bit_cnt       <= '0;
                        state         <= sd_ctrl_pkg::TX_WAIT_EDGE;
                    end
                end
                sd_ctrl_pkg::TX_WAIT_EDGE, sd_ctrl_pkg::TX_SHIFT: begin
                    if (line.drive_tick) begin
                        line.cmd_oe  <= 1'b1;
                        line.cmd_out <= next_bit;
                        bit_cnt      <= bit_cnt + 1'b1;
                        if (bit_cnt == 6'(sd_proto_pkg::FRAME_BITS - 1)) begin
                            state <= sd_ctrl_pkg::TX_DONE;
                        end else begin
                            state <= sd_ctrl_pkg::TX_SHIFT;
                        end
                    end
                end
                sd_ctrl_pkg::TX_DONE: begin
                    // End bit has been on the line for a full SD clock
                    if (line.drive_tick) begin
                        line.cmd_oe  <= 1'b0;
                        line.cmd_out <= 1'b1;
                        cmd_done     <= 1'b1;
                        resp_arm     <= resp_expect_q;
                        state        <= sd_ctrl_pkg::TX_IDLE;
                    end
                end
                default: state <= sd_ctrl_pkg::TX_IDLE;
            endcase
        end
    end

    sd_crc7 sd_crc7_inst (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (accept),
        .en       (crc_en),
        .bit_in   (shreg[sd_proto_pkg::PAYLOAD_BITS-1]),
        .crc      (crc)
    );

endmodule

// File: logic/sd_resp_rx.sv
module sd_resp_rx #(
    parameter int RESP_TIMEOUT_CLKS = sd_ctrl_pkg::NCR_MAX
) (
    input  logic                clk_fast,
    input  logic                arst_n,
    input  logic                resp_arm,
    output logic                resp_done,
    output sd_proto_pkg::frame_t resp_data,
    output logic                resp_crc_err,
    output logic                resp_timeout,
    sd_cmd_line_if.rx           line
);

    localparam int TW = $clog2(RESP_TIMEOUT_CLKS + 1);

    sd_ctrl_pkg::rx_state_t state;
    sd_proto_pkg::frame_t   shreg;
    sd_proto_pkg::crc7_t    crc;

    logic [TW-1:0] wait_cnt;
    logic [5:0]    bit_cnt;
    logic          start_seen;
    logic          crc_en;

    assign start_seen = (state == sd_ctrl_pkg::RX_SEARCH) && line.sample_tick && !line.cmd_in;

    // Start bit through argument feed the CRC
    assign crc_en = start_seen ||
                    ((state == sd_ctrl_pkg::RX_SHIFT) && line.sample_tick &&
                     (bit_cnt < 6'(sd_proto_pkg::PAYLOAD_BITS)));

    // ==============================
    // Frame capture
    // ==============================
    always_ff @(posedge clk_fast) begin
        if (start_seen || ((state == sd_ctrl_pkg::RX_SHIFT) && line.sample_tick)) begin
            shreg <= {shreg[sd_proto_pkg::FRAME_BITS-2:0], line.cmd_in};
        end
        if (state == sd_ctrl_pkg::RX_CHECK) begin
            resp_data <= shreg;
        end
    end

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state        <= sd_ctrl_pkg::RX_IDLE;
            wait_cnt     <= '0;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
            resp_timeout <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            if (resp_arm) begin
                wait_cnt <= '0;
                state    <= sd_ctrl_pkg::RX_SEARCH;
            end else begin
                case (state)
                    sd_ctrl_pkg::RX_SEARCH: begin
                        if (start_seen) begin
                            bit_cnt <= 6'd1;
                            state   <= sd_ctrl_pkg::RX_SHIFT;
                        end else if (line.sample_tick) begin
                            if (wait_cnt == TW'(RESP_TIMEOUT_CLKS - 1)) begin
                                // Card never answered
                                resp_done    <= 1'b1;
                                resp_timeout <= 1'b1;
                                resp_crc_err <= 1'b0;
                                state        <= sd_ctrl_pkg::RX_IDLE;
                            end else begin
                                wait_cnt <= wait_cnt + 1'b1;
                            end
                        end
                    end
                    sd_ctrl_pkg::RX_SHIFT: begin
                        if (line.sample_tick) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 6'(sd_proto_pkg::FRAME_BITS - 1)) begin
                                state <= sd_ctrl_pkg::RX_CHECK;
                            end
                        end
                    end
                    sd_ctrl_pkg::RX_CHECK: begin
                        // CRC in bits 7..1, end bit must be high
                        resp_crc_err <= (shreg[7:1] != crc) || !shreg[0];
                        resp_timeout <= 1'b0;
                        resp_done    <= 1'b1;
                        state        <= sd_ctrl_pkg::RX_IDLE;
                    end
                    default: state <= sd_ctrl_pkg::RX_IDLE;
                endcase
            end
        end
    end

    sd_crc7 sd_crc7_inst (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (resp_arm),
        .en       (crc_en),
        .bit_in   (line.cmd_in),
        .crc      (crc)
    );

endmodule

// File: logic/sd_host_top.sv
module sd_host_top #(
    parameter int CLK_FREQ_HZ       = 120_000_000,
    parameter int RESP_TIMEOUT_CLKS = sd_ctrl_pkg::NCR_MAX
) (
    input  logic                      clk_fast,
    input  logic                      arst_n,
    input  logic                      cfg_write,
    input  sd_ctrl_pkg::half_period_t cfg_half_period,
    input  logic                      cfg_clk_en,
    input  logic                      cmd_start,
    input  sd_proto_pkg::payload_t    cmd_payload,
    input  logic                      resp_expect,
    output logic                      cmd_busy,
    output logic                      cmd_done,
    output logic                      resp_done,
    output sd_proto_pkg::frame_t      resp_data,
    output logic                      resp_crc_err,
    output logic                      resp_timeout,
    output logic                      sdcard_clk,
    output logic                      sdcard_cmd_out,
    output logic                      sdcard_cmd_oe,
    input  logic                      sdcard_cmd_in
);

    sd_ctrl_pkg::half_period_t half_period;

    logic clk_en;
    logic resp_arm;

    sd_cmd_line_if line ();

    // CMD pad
    assign sdcard_cmd_out = line.cmd_out;
    assign sdcard_cmd_oe  = line.cmd_oe;
    assign line.cmd_in    = sdcard_cmd_in;

    // ==============================
    // Clocking
    // ==============================
    sd_link_cfg #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) sd_link_cfg_inst (
        .clk_fast (clk_fast), .arst_n (arst_n), .cfg_write (cfg_write),
        .cfg_half_period (cfg_half_period), .cfg_clk_en (cfg_clk_en),
        .half_period (half_period), .clk_en (clk_en)
    );

    sd_clock_gen sd_clock_gen_inst (
        .clk_fast (clk_fast), .arst_n (arst_n), .half_period (half_period),
        .clk_en (clk_en), .sdcard_clk (sdcard_clk), .line (line.clk)
    );

    // ==============================
    // Command and response
    // ==============================
    sd_cmd_tx sd_cmd_tx_inst (
        .clk_fast (clk_fast), .arst_n (arst_n), .cmd_start (cmd_start),
        .cmd_payload (cmd_payload), .resp_expect (resp_expect), .cmd_busy (cmd_busy),
        .cmd_done (cmd_done), .resp_arm (resp_arm), .line (line.tx)
    );

    sd_resp_rx #(.RESP_TIMEOUT_CLKS(RESP_TIMEOUT_CLKS)) sd_resp_rx_inst (
        .clk_fast (clk_fast), .arst_n (arst_n), .resp_arm (resp_arm),
        .resp_done (resp_done), .resp_data (resp_data), .resp_crc_err (resp_crc_err),
        .resp_timeout (resp_timeout), .line (line.rx)
    );

endmodule

// File: testbench/tb_sd_card_model.sv
module tb_sd_card_model (
    input  logic                 sdcard_clk,
    input  logic                 cmd_oe,
    input  logic                 cmd_line,
    input  sd_proto_pkg::frame_t resp_frame,
    input  logic                 resp_enable,
    output logic                 card_cmd,
    output sd_proto_pkg::frame_t frame,
    output logic                 frame_valid,
    output int                   frame_count
);

    timeunit 1ns;
    timeprecision 1ps;

    sd_proto_pkg::frame_t shreg;
    int                   bit_cnt;
    event                 frame_seen;

    initial begin
        card_cmd    = 1'b1;
        frame       = '0;
        frame_valid = 1'b0;
        frame_count = 0;
        shreg       = '0;
        bit_cnt     = 0;
    end

    // Host command, sampled on the rising SD clock while the host drives CMD
    always @(posedge sdcard_clk) begin
        if (cmd_oe) begin
            shreg = {shreg[sd_proto_pkg::FRAME_BITS-2:0], cmd_line};
            bit_cnt++;
            if (bit_cnt == sd_proto_pkg::FRAME_BITS) begin
                frame       <= shreg;
                // Start bit low, transmission bit high, end bit high
                frame_valid <= (shreg[sd_proto_pkg::FRAME_BITS-1 -: 2] == 2'b01) && shreg[0];
                frame_count <= frame_count + 1;
                bit_cnt = 0;
                -> frame_seen;
            end
        end
    end

    // Scripted response, 8 SD clocks after the command ends
    initial begin
        forever begin
            @(frame_seen);
            if (resp_enable) begin
                repeat (8) @(negedge sdcard_clk);
                for (int i = sd_proto_pkg::FRAME_BITS - 1; i >= 0; i--) begin
                    card_cmd <= resp_frame[i];
                    @(negedge sdcard_clk);
                end
                card_cmd <= 1'b1;
            end
        end
    end

endmodule

// File: testbench/tb_sd_host.sv
module tb_sd_host;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_FREQ_HZ = 50_000_000;
    localparam int ROWS        = 6;
    localparam int MAX_HALF    = 5;

    // Command, longest start-bit wait and response, per row
    localparam int ROW_SD_CLKS = 56 + sd_ctrl_pkg::NCR_MAX + 48;
    localparam longint WATCHDOG_NS =
        longint'(ROWS) * ROW_SD_CLKS * 2 * MAX_HALF * 20 * 2 + 20_000;

    // x^7 + x^3 + 1 without the x^7 term
    localparam logic [6:0] POLY = 7'b000_1001;

    // Card behaviour per row
    localparam logic [1:0] ACT_GOOD    = 2'd0;
    localparam logic [1:0] ACT_BAD_CRC = 2'd1;
    localparam logic [1:0] ACT_BAD_END = 2'd2;
    localparam logic [1:0] ACT_SILENT  = 2'd3;

    typedef struct packed {
        logic [7:0] half_period;
        logic [5:0] index;
        logic       resp_expect;
        logic [1:0] action;
        logic       exp_crc_err;
        logic       exp_timeout;
    } row_t;

    row_t rows [ROWS] = '{
        '{8'd2, 6'd0,  1'b1, ACT_GOOD,    1'b0, 1'b0},
        '{8'd3, 6'd8,  1'b1, ACT_BAD_CRC, 1'b1, 1'b0},
        '{8'd2, 6'd17, 1'b1, ACT_BAD_END, 1'b1, 1'b0},
        '{8'd4, 6'd55, 1'b1, ACT_SILENT,  1'b0, 1'b1},
        '{8'd3, 6'd7,  1'b0, ACT_SILENT,  1'b0, 1'b0},
        '{8'd5, 6'd13, 1'b1, ACT_GOOD,    1'b0, 1'b0}
    };

    logic                      clk_fast;
    logic                      arst_n;
    logic                      cfg_write;
    sd_ctrl_pkg::half_period_t cfg_half_period;
    logic                      cfg_clk_en;
    logic                      cmd_start;
    sd_proto_pkg::payload_t    cmd_payload;
    logic                      resp_expect;
    logic                      cmd_busy;
    logic                      cmd_done;
    logic                      resp_done;
    sd_proto_pkg::frame_t      resp_data;
    logic                      resp_crc_err;
    logic                      resp_timeout;
    logic                      sdcard_clk;
    logic                      sdcard_cmd_out;
    logic                      sdcard_cmd_oe;
    logic                      cmd_line;
    logic                      card_cmd;
    sd_proto_pkg::frame_t      card_frame;
    logic                      card_frame_valid;
    int                        card_frame_count;
    sd_proto_pkg::frame_t      card_resp;
    logic                      card_resp_en;

    int seed = 4;
    int cmd_done_count = 0;
    int resp_done_count = 0;

    // Shared CMD line, the card drives whenever the host releases it
    assign cmd_line = sdcard_cmd_oe ? sdcard_cmd_out : card_cmd;

    sd_host_top #(
        .CLK_FREQ_HZ       (CLK_FREQ_HZ),
        .RESP_TIMEOUT_CLKS (sd_ctrl_pkg::NCR_MAX)
    ) sd_host_top_inst (
        .clk_fast (clk_fast), .arst_n (arst_n), .cfg_write (cfg_write),
        .cfg_half_period (cfg_half_period), .cfg_clk_en (cfg_clk_en),
        .cmd_start (cmd_start), .cmd_payload (cmd_payload), .resp_expect (resp_expect),
        .cmd_busy (cmd_busy), .cmd_done (cmd_done), .resp_done (resp_done),
        .resp_data (resp_data), .resp_crc_err (resp_crc_err), .resp_timeout (resp_timeout),
        .sdcard_clk (sdcard_clk), .sdcard_cmd_out (sdcard_cmd_out),
        .sdcard_cmd_oe (sdcard_cmd_oe), .sdcard_cmd_in (cmd_line)
    );

    tb_sd_card_model tb_sd_card_model_inst (
        .sdcard_clk (sdcard_clk), .cmd_oe (sdcard_cmd_oe), .cmd_line (cmd_line),
        .resp_frame (card_resp), .resp_enable (card_resp_en), .card_cmd (card_cmd),
        .frame (card_frame), .frame_valid (card_frame_valid), .frame_count (card_frame_count)
    );

    initial begin
        clk_fast = 1'b0;
        forever #10 clk_fast = ~clk_fast;
    end

    always @(posedge clk_fast) begin
        if (cmd_done) begin
            cmd_done_count <= cmd_done_count + 1;
        end
        if (resp_done) begin
            resp_done_count <= resp_done_count + 1;
        end
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic step();
        @(posedge clk_fast);
        #2;
    endtask

    // Serial CRC7, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] data);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ POLY;
            end
        end
        return c;
    endfunction

    task automatic write_config(input sd_ctrl_pkg::half_period_t d);
        cfg_half_period = d;
        cfg_clk_en      = 1'b1;
        cfg_write       = 1'b1;
        step();
        cfg_write = 1'b0;
    endtask

    // First two edges may still belong to the old setting
    task automatic measure_phases(input int d);
        logic prev;
        int   edges;
        int   run;
        prev  = sdcard_clk;
        edges = 0;
        run   = 0;
        while (edges < 5) begin
            step();
            run++;
            if (sdcard_clk != prev) begin
                edges++;
                if (edges >= 3 && prev) begin
                    check_value("sdcard_clk high phase", 64'(run), 64'(d));
                end else if (edges >= 3) begin
                    check_value("sdcard_clk low phase", 64'(run), 64'(d));
                end
                run  = 0;
                prev = sdcard_clk;
            end
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int                     resp_target;
        int                     flip;
        logic [31:0]            arg;
        logic [31:0]            rnd;
        logic [31:0]            resp_arg;
        sd_proto_pkg::payload_t payload;
        sd_proto_pkg::payload_t resp_payload;
        sd_proto_pkg::frame_t   exp_frame;

        arst_n          = 1'b0;
        cfg_write       = 1'b0;
        cfg_half_period = '0;
        cfg_clk_en      = 1'b1;
        cmd_start       = 1'b0;
        cmd_payload     = '0;
        resp_expect     = 1'b0;
        card_resp       = '1;
        card_resp_en    = 1'b0;
        resp_target     = 0;

        // Known answer: CMD0 with argument 0 carries CRC 0x4A
        check_value("crc7 of CMD0", 64'(crc7_of(40'h40_0000_0000)), 64'h4a);

        repeat (8) step();
        check_value("outputs in reset",
                    64'({cmd_busy, cmd_done, resp_done, resp_crc_err, resp_timeout,
                         sdcard_clk, sdcard_cmd_oe}), 64'h0);
        arst_n = 1'b1;

        for (int r = 0; r < ROWS; r++) begin
            write_config(rows[r].half_period);
            measure_phases(int'(rows[r].half_period));

            arg      = $random(seed);
            rnd      = $random(seed);
            resp_arg = $random(seed);

            payload      = {2'b01, rows[r].index, arg};
            exp_frame    = {payload, crc7_of(payload), 1'b1};
            resp_payload = {2'b00, rnd[5:0], resp_arg};
            card_resp    = {resp_payload, crc7_of(resp_payload), 1'b1};
            if (rows[r].action == ACT_BAD_CRC) begin
                flip = int'(rnd[8:6]) % 7;
                card_resp[1 + flip] = ~card_resp[1 + flip];
            end else if (rows[r].action == ACT_BAD_END) begin
                card_resp[0] = 1'b0;
            end
            card_resp_en = (rows[r].action != ACT_SILENT);

            cmd_payload = payload;
            resp_expect = rows[r].resp_expect;
            cmd_start   = 1'b1;
            step();
            cmd_start = 1'b0;
            check_value("cmd_busy", 64'(cmd_busy), 64'd1);

            // Second start while busy must be ignored
            step();
            cmd_start = 1'b1;
            step();
            cmd_start = 1'b0;

            while (cmd_done_count < r + 1) begin
                step();
            end
            check_value("card frame_count", 64'(card_frame_count), 64'(r + 1));
            check_value("card frame_valid", 64'(card_frame_valid), 64'd1);
            check_value("card frame", 64'(card_frame), 64'(exp_frame));
            check_value("cmd_busy", 64'(cmd_busy), 64'd0);

            if (rows[r].resp_expect) begin
                resp_target++;
                while (resp_done_count < resp_target) begin
                    step();
                end
                check_value("resp_timeout", 64'(resp_timeout), 64'(rows[r].exp_timeout));
                check_value("resp_crc_err", 64'(resp_crc_err), 64'(rows[r].exp_crc_err));
                if (rows[r].action != ACT_SILENT) begin
                    check_value("resp_data", 64'(resp_data), 64'(card_resp));
                end
            end else begin
                // Longer than any response could take
                repeat (sd_ctrl_pkg::NCR_MAX + 48) @(posedge sdcard_clk);
                step();
            end

            check_value("resp_done count", 64'(resp_done_count), 64'(resp_target));
            check_value("cmd_done count", 64'(cmd_done_count), 64'(r + 1));
            check_value("card frame_count", 64'(card_frame_count), 64'(r + 1));
        end

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped making progress",
                 WATCHDOG_NS);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation timed out");
    end

endmodule

// File: list.f
logic/sd_proto_pkg.sv
logic/sd_ctrl_pkg.sv
logic/sd_cmd_line_if.sv
logic/sd_link_cfg.sv
logic/sd_clock_gen.sv
logic/sd_crc7.sv
logic/sd_cmd_tx.sv
logic/sd_resp_rx.sv
logic/sd_host_top.sv
testbench/tb_sd_card_model.sv
testbench/tb_sd_host.sv

// File: Makefile
# Verilator flow for the SD command-line host

VERILATOR ?= verilator
TOP       ?= tb_sd_host
RTL_TOP   ?= sd_host_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)
SIM_ARGS  ?=

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) $(filter logic/%,$(shell cat $(FILE_LIST))) \
		--top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
